//--- Makefile
# Verilator build and regression of the tcdm interconnect

TOP             ?= tcdm_tb
LOG             ?= sim.log
FILELIST        ?= list.f
BUILD_DIR       ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: TOP LOG FILELIST BUILD_DIR VERILATOR VERILATOR_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/tcdm_pkg.sv
/*
  shared definitions of the tcdm interconnect
  - widths and counts of the master, bank and memory sides
  - address union with its sram and scm views
  - records passed between decode, request pipe and response pipe
*/
package tcdm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  // master side
  localparam int N_MASTER   = 4;
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int BE_W       = DATA_W / 8;
  localparam int BYTE_OFF_W = $clog2(BE_W);

  // bank side, word interleaved
  localparam int N_BANK     = 4;
  localparam int BANK_W     = $clog2(N_BANK);

  // rows seen by the interconnect, top bit picks the region
  localparam int ROW_W      = 11;
  localparam int SRAM_ROW_W = 10;
  localparam int SCM_ROW_W  = 8;

  // region bit sits on top of row, bank index and byte offset
  localparam int REGION_BIT = ROW_W + BANK_W + BYTE_OFF_W - 1;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic
  {
    SRAM = 1'b0,
    SCM  = 1'b1
  } region_e;

  typedef logic [N_MASTER-1:0] master_id_t;

  // sram view, full row below the region bit
  typedef struct packed
  {
    region_e                 region;
    logic [SRAM_ROW_W-1:0]   row;
    logic [BANK_W-1:0]       bank;
    logic [BYTE_OFF_W-1:0]   offset;
  } sram_addr_t;

  // scm view, smaller array so the top row bits are dropped
  typedef struct packed
  {
    region_e                          region;
    logic [SRAM_ROW_W-SCM_ROW_W-1:0]  unused;
    logic [SCM_ROW_W-1:0]             row;
    logic [BANK_W-1:0]                bank;
    logic [BYTE_OFF_W-1:0]            offset;
  } scm_addr_t;

  // low address bits, the region bit tells which view holds
  typedef union packed
  {
    sram_addr_t sram;
    scm_addr_t  scm;
  } tcdm_addr_u;

  // wen high means load
  typedef struct packed
  {
    logic               req;
    logic [ADDR_W-1:0]  addr;
    logic               wen;
    logic [DATA_W-1:0]  wdata;
    logic [BE_W-1:0]    be;
  } master_req_t;

  typedef struct packed
  {
    logic               r_valid;
    logic [DATA_W-1:0]  r_rdata;
  } master_rsp_t;

  // granted request of one bank, row is below the region bit
  typedef struct packed
  {
    logic                   req;
    region_e                region;
    logic [SRAM_ROW_W-1:0]  row;
    logic                   wen;
    logic [DATA_W-1:0]      wdata;
    logic [BE_W-1:0]        be;
    master_id_t             id;
  } bank_req_t;

  typedef struct packed
  {
    logic                   req;
    logic [SRAM_ROW_W-1:0]  addr;
    logic                   wen;
    logic [DATA_W-1:0]      wdata;
    logic [BE_W-1:0]        be;
  } sram_req_t;

  typedef struct packed
  {
    logic                   req;
    logic [SCM_ROW_W-1:0]   addr;
    logic                   wen;
    logic [DATA_W-1:0]      wdata;
    logic [BE_W-1:0]        be;
  } scm_req_t;

  // access in flight, aligned with the memory read data
  typedef struct packed
  {
    logic        valid;
    region_e     region;
    master_id_t  id;
  } pend_t;

endpackage

//--- list.f
common/tcdm_pkg.sv
xbar/tcdm_bank_arbiter.sv
xbar/tcdm_xbar_req.sv
pipe/tcdm_pipe_req.sv
pipe/tcdm_pipe_resp.sv
source/tcdm_interconnect.sv
verif/tcdm_mem_model.sv
verif/tcdm_tb.sv

//--- pipe/tcdm_pipe_req.sv
/*
  request pipe
  - one request register per bank
  - steering to the sram or scm port by the region bit
  - pending record for the response pipe
*/
`timescale 1ns/1ps

module tcdm_pipe_req
  import tcdm_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n_i,
  input  bank_req_t [N_BANK-1:0]    bank_req_i,
  output sram_req_t [N_BANK-1:0]    sram_req_o,
  output scm_req_t [N_BANK-1:0]     scm_req_o,
  output pend_t [N_BANK-1:0]        pend_o
);

  logic [N_BANK-1:0]       req_valid_q;
  bank_req_t [N_BANK-1:0]  req_q;
  pend_t [N_BANK-1:0]      pend_q;

  // valid flags and pending records
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      req_valid_q <= '0;
      pend_q      <= '0;
    end
    else
    begin
      for (int b = 0; b < N_BANK; b++)
      begin
        req_valid_q[b]   <= bank_req_i[b].req;
        // follows the memory access by one cycle, lines up with rdata
        pend_q[b].valid  <= req_valid_q[b];
        pend_q[b].region <= req_q[b].region;
        pend_q[b].id     <= req_q[b].id;
      end
    end
  end

  // payload, only loaded on a granted request
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < N_BANK; b++)
      if (bank_req_i[b].req)
        req_q[b] <= bank_req_i[b];
  end

  // steering, the payload fans out to both ports
  always_comb
  begin
    for (int b = 0; b < N_BANK; b++)
    begin
      sram_req_o[b].req   = req_valid_q[b] && (req_q[b].region == SRAM);
      sram_req_o[b].addr  = req_q[b].row;
      sram_req_o[b].wen   = req_q[b].wen;
      sram_req_o[b].wdata = req_q[b].wdata;
      sram_req_o[b].be    = req_q[b].be;

      // scm keeps the low row bits only
      scm_req_o[b].req    = req_valid_q[b] && (req_q[b].region == SCM);
      scm_req_o[b].addr   = req_q[b].row[SCM_ROW_W-1:0];
      scm_req_o[b].wen    = req_q[b].wen;
      scm_req_o[b].wdata  = req_q[b].wdata;
      scm_req_o[b].be     = req_q[b].be;
    end
  end

  assign pend_o = pend_q;

  for (genvar b = 0; b < N_BANK; b++)
  begin : g_port_chk
    a_one_region : assert property (@(posedge clk) disable iff (!rst_n_i)
      !(sram_req_o[b].req && scm_req_o[b].req));
  end

endmodule

//--- pipe/tcdm_pipe_resp.sv
/*
  response pipe
  - rdata select by the pending region
  - response register per bank, tagged with the master id
  - return to the masters by id bit
*/
`timescale 1ns/1ps

module tcdm_pipe_resp
  import tcdm_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n_i,
  input  pend_t [N_BANK-1:0]             pend_i,
  input  logic [N_BANK-1:0][DATA_W-1:0]  sram_rdata_i,
  input  logic [N_BANK-1:0][DATA_W-1:0]  scm_rdata_i,
  output master_rsp_t [N_MASTER-1:0]     master_rsp_o
);

  logic [N_BANK-1:0][DATA_W-1:0]    rdata_sel;
  logic [N_BANK-1:0]                valid_q;
  master_id_t [N_BANK-1:0]          id_q;
  logic [N_BANK-1:0][DATA_W-1:0]    rdata_q;
  // bank b answers master m this cycle
  logic [N_MASTER-1:0][N_BANK-1:0]  hit;

  // region of the access picks the memory
  always_comb
  begin
    for (int b = 0; b < N_BANK; b++)
      rdata_sel[b] = (pend_i[b].region == SCM) ? scm_rdata_i[b] : sram_rdata_i[b];
  end

  // valid for loads and stores alike
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      valid_q <= '0;
    else
      for (int b = 0; b < N_BANK; b++)
        valid_q[b] <= pend_i[b].valid;
  end

  // id and data held until the next access of the bank
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < N_BANK; b++)
    begin
      if (pend_i[b].valid)
      begin
        id_q[b]    <= pend_i[b].id;
        rdata_q[b] <= rdata_sel[b];
      end
    end
  end

  // route by id, at most one bank per master
  always_comb
  begin
    for (int m = 0; m < N_MASTER; m++)
    begin
      master_rsp_o[m] = '0;
      for (int b = 0; b < N_BANK; b++)
      begin
        hit[m][b] = valid_q[b] && id_q[b][m];
        if (hit[m][b])
          master_rsp_o[m].r_rdata = master_rsp_o[m].r_rdata | rdata_q[b];
      end
      master_rsp_o[m].r_valid = |hit[m];
    end
  end

  // single grant per master, three cycles back, keeps returns apart
  for (genvar m = 0; m < N_MASTER; m++)
  begin : g_rsp_chk
    a_one_return : assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(hit[m]));
  end

endmodule

//--- source/tcdm_interconnect.sv
/*
  tcdm interconnect top level
  - decode and per-bank arbitration
  - request pipe towards the sram and scm ports
  - response pipe back to the masters
*/
`timescale 1ns/1ps

module tcdm_interconnect
  import tcdm_pkg::*;
(
  input  logic                             clk,
  input  logic                             rst_n_i,

  // master side
  input  master_req_t [N_MASTER-1:0]       master_req_i,
  output logic [N_MASTER-1:0]              master_gnt_o,
  output master_rsp_t [N_MASTER-1:0]       master_rsp_o,

  // memory side, one sram and one scm port per bank
  output sram_req_t [N_BANK-1:0]           sram_req_o,
  output scm_req_t [N_BANK-1:0]            scm_req_o,
  input  logic [N_BANK-1:0][DATA_W-1:0]    sram_rdata_i,
  input  logic [N_BANK-1:0][DATA_W-1:0]    scm_rdata_i
);

  // granted request per bank, combinational from the masters
  bank_req_t [N_BANK-1:0]  bank_req;
  // accesses in flight, one per bank
  pend_t [N_BANK-1:0]      pend;

  ////////////////////////////////////////////////////////////////////////////
  // stage 0: decode and arbitrate
  ////////////////////////////////////////////////////////////////////////////

  tcdm_xbar_req i_xbar_req
  (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .master_req_i ( master_req_i ),
    .master_gnt_o ( master_gnt_o ),
    .bank_req_o   ( bank_req     )
  );

  ////////////////////////////////////////////////////////////////////////////
  // stage 1: request register, region steering
  ////////////////////////////////////////////////////////////////////////////

  tcdm_pipe_req i_pipe_req
  (
    .clk        ( clk        ),
    .rst_n_i    ( rst_n_i    ),
    .bank_req_i ( bank_req   ),
    .sram_req_o ( sram_req_o ),
    .scm_req_o  ( scm_req_o  ),
    .pend_o     ( pend       )
  );

  ////////////////////////////////////////////////////////////////////////////
  // stage 2: response register, return by id
  ////////////////////////////////////////////////////////////////////////////

  tcdm_pipe_resp i_pipe_resp
  (
    .clk          ( clk          ),
    .rst_n_i      ( rst_n_i      ),
    .pend_i       ( pend         ),
    .sram_rdata_i ( sram_rdata_i ),
    .scm_rdata_i  ( scm_rdata_i  ),
    .master_rsp_o ( master_rsp_o )
  );

endmodule

//--- verif/tcdm_mem_model.sv
/*
  behavioral memory model
  - sram and scm arrays of every bank
  - byte-enable writes, read data one cycle after the request
*/
`timescale 1ns/1ps

module tcdm_mem_model
  import tcdm_pkg::*;
(
  input  logic                           clk,
  input  sram_req_t [N_BANK-1:0]         sram_req_i,
  input  scm_req_t [N_BANK-1:0]          scm_req_i,
  output logic [N_BANK-1:0][DATA_W-1:0]  sram_rdata_o,
  output logic [N_BANK-1:0][DATA_W-1:0]  scm_rdata_o
);

  logic [DATA_W-1:0]  sram_mem [N_BANK][2**SRAM_ROW_W];
  logic [DATA_W-1:0]  scm_mem  [N_BANK][2**SCM_ROW_W];

  // power-up contents, unique per region, bank and row
  initial
  begin
    for (int b = 0; b < N_BANK; b++)
    begin
      for (int r = 0; r < 2**SRAM_ROW_W; r++)
        sram_mem[b][r] = 32'h3c00_0000 | (b << 16) | r;
      for (int r = 0; r < 2**SCM_ROW_W; r++)
        scm_mem[b][r] = 32'h3c10_0000 | (b << 16) | r;
    end
  end

  // old word is returned on stores too
  always @(posedge clk)
  begin
    for (int b = 0; b < N_BANK; b++)
    begin
      if (sram_req_i[b].req)
      begin
        sram_rdata_o[b] <= sram_mem[b][sram_req_i[b].addr];
        for (int i = 0; i < BE_W; i++)
          if (!sram_req_i[b].wen && sram_req_i[b].be[i])
            sram_mem[b][sram_req_i[b].addr][8*i +: 8] <= sram_req_i[b].wdata[8*i +: 8];
      end
      if (scm_req_i[b].req)
      begin
        scm_rdata_o[b] <= scm_mem[b][scm_req_i[b].addr];
        for (int i = 0; i < BE_W; i++)
          if (!scm_req_i[b].wen && scm_req_i[b].be[i])
            scm_mem[b][scm_req_i[b].addr][8*i +: 8] <= scm_req_i[b].wdata[8*i +: 8];
      end
    end
  end

endmodule

//--- verif/tcdm_tb.sv
/*
  testbench of the tcdm interconnect
  - clock, reset and memory model around the DUT
  - response monitor against a reference memory
  - directed tests of decode, arbitration and pipeline latency
*/
`timescale 1ns/1ps

module tcdm_tb
  import tcdm_pkg::*;
();

  localparam int TIMEOUT = 50;

  // one access in flight and the cycle of its r_valid
  typedef struct packed
  {
    logic [31:0]        due;
    logic               load;
    logic [DATA_W-1:0]  data;
  } expect_t;

  logic                           clk;
  logic                           rst_n;
  master_req_t [N_MASTER-1:0]     master_req;
  logic [N_MASTER-1:0]            master_gnt;
  master_rsp_t [N_MASTER-1:0]     master_rsp;
  sram_req_t [N_BANK-1:0]         sram_req;
  scm_req_t [N_BANK-1:0]          scm_req;
  logic [N_BANK-1:0][DATA_W-1:0]  sram_rdata;
  logic [N_BANK-1:0][DATA_W-1:0]  scm_rdata;

  // reference memory by region, bank and row
  logic [DATA_W-1:0]  ref_mem [2][N_BANK][2**SRAM_ROW_W];
  expect_t            exp_q [N_MASTER][$];
  logic [31:0]        rnd_state = 32'ha7d9;
  int                 cyc = 0;

  tcdm_interconnect i_dut
  (
    .clk          ( clk        ),
    .rst_n_i      ( rst_n      ),
    .master_req_i ( master_req ),
    .master_gnt_o ( master_gnt ),
    .master_rsp_o ( master_rsp ),
    .sram_req_o   ( sram_req   ),
    .scm_req_o    ( scm_req    ),
    .sram_rdata_i ( sram_rdata ),
    .scm_rdata_i  ( scm_rdata  )
  );

  tcdm_mem_model i_mem
  (
    .clk          ( clk        ),
    .sram_req_i   ( sram_req   ),
    .scm_req_i    ( scm_req    ),
    .sram_rdata_o ( sram_rdata ),
    .scm_rdata_o  ( scm_rdata  )
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_random();
    rnd_state ^= rnd_state << 13;
    rnd_state ^= rnd_state >> 17;
    rnd_state ^= rnd_state << 5;
    return rnd_state;
  endfunction

  // region bit 14 and bank bits 3:2
  // row at 13:4 for sram or 11:4 for scm, other bits random
  function automatic logic [ADDR_W-1:0] make_addr(logic region, int bank, int row);
    logic [ADDR_W-1:0] a;
    a      = next_random();
    a[1:0] = 2'b00;
    a[3:2] = bank[1:0];
    a[14]  = region;
    if (region)
      a[11:4] = row[7:0];
    else
      a[13:4] = row[9:0];
    return a;
  endfunction

  function automatic master_req_t req_word(logic [ADDR_W-1:0] addr, logic wen,
                                           logic [DATA_W-1:0] wdata, logic [BE_W-1:0] be);
    return '{req: 1'b1, addr: addr, wen: wen, wdata: wdata, be: be};
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(logic [DATA_W-1:0] old,
                                                    logic [DATA_W-1:0] wdata,
                                                    logic [BE_W-1:0] be);
    for (int i = 0; i < BE_W; i++)
      if (be[i])
        old[8*i +: 8] = wdata[8*i +: 8];
    return old;
  endfunction

  task automatic fail_run(string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rdata(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
  endtask

  task automatic check_gnt(string name, logic [N_MASTER-1:0] got, logic [N_MASTER-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
  endtask

  task automatic check_port(string name, logic [N_BANK-1:0] got, logic [N_BANK-1:0] exp);
    if (got !== exp)
      fail_run($sformatf("** Error at %0t: %s = %b, expected %b", $time, name, got, exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // response monitor
  ////////////////////////////////////////////////////////////////////////////

  // r_valid due 3 cycles after the grant and data checked for loads
  always @(negedge clk)
  begin : monitor
    expect_t      e;
    master_req_t  q;
    logic         region;
    int           bank;
    int           row;
    if (rst_n)
    begin
      for (int m = 0; m < N_MASTER; m++)
      begin
        if (master_rsp[m].r_valid && exp_q[m].size() == 0)
          fail_run($sformatf("master %0d got r_valid with no access in flight", m));
        else if (master_rsp[m].r_valid)
        begin
          e = exp_q[m].pop_front();
          if (e.due != cyc)
            fail_run($sformatf("master %0d got r_valid in the wrong cycle", m));
          else if (e.load)
            check_rdata($sformatf("master_rsp_o[%0d].r_rdata", m), master_rsp[m].r_rdata, e.data);
        end
        else if (exp_q[m].size() != 0 && exp_q[m][0].due == cyc)
          fail_run($sformatf("master %0d missed its r_valid", m));
        if (master_gnt[m])
        begin
          q      = master_req[m];
          region = q.addr[14];
          bank   = int'(q.addr[3:2]);
          row    = region ? int'(q.addr[11:4]) : int'(q.addr[13:4]);
          if (!q.wen)
            ref_mem[region][bank][row] = merge_bytes(ref_mem[region][bank][row], q.wdata, q.be);
          e.due  = cyc + 3;
          e.load = q.wen;
          e.data = ref_mem[region][bank][row];
          exp_q[m].push_back(e);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // driving tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_grant(int m);
    int n;
    n = 0;
    @(negedge clk);
    while (!master_gnt[m] && n < TIMEOUT)
    begin
      @(negedge clk);
      n++;
    end
    if (!master_gnt[m])
      fail_run($sformatf("master %0d was never granted", m));
  endtask

  // until every access has returned
  // sampled on the rising edge, away from the monitor
  task automatic wait_idle();
    int n;
    int busy;
    n = 0;
    do
    begin
      @(posedge clk);
      busy = 0;
      for (int m = 0; m < N_MASTER; m++)
        busy += exp_q[m].size();
      n++;
    end while (busy != 0 && n < TIMEOUT);
    if (busy != 0)
      fail_run("responses still missing after the timeout");
  endtask

  task automatic access(int m, logic [ADDR_W-1:0] addr, logic wen,
                        logic [DATA_W-1:0] wdata, logic [BE_W-1:0] be);
    @(posedge clk);
    master_req[m] <= req_word(addr, wen, wdata, be);
    wait_grant(m);
    @(posedge clk);
    master_req[m].req <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    logic [N_BANK-1:0]    sram_v;
    logic [N_BANK-1:0]    scm_v;
    logic [N_MASTER-1:0]  valid_v;
    @(negedge clk);
    for (int b = 0; b < N_BANK; b++)
    begin
      sram_v[b] = sram_req[b].req;
      scm_v[b]  = scm_req[b].req;
    end
    for (int m = 0; m < N_MASTER; m++)
      valid_v[m] = master_rsp[m].r_valid;
    check_port("sram_req_o.req", sram_v, '0);
    check_port("scm_req_o.req", scm_v, '0);
    check_gnt("master_rsp_o.r_valid", valid_v, '0);
  endtask

  // store then load in every region and bank
  task automatic test_write_read();
    logic [ADDR_W-1:0]  addr;
    int                 m;
    int                 row;
    for (int r = 0; r < 2; r++)
    begin
      for (int b = 0; b < N_BANK; b++)
      begin
        m    = (b + r) % N_MASTER;
        row  = int'(next_random() % (r ? 2**SCM_ROW_W : 2**SRAM_ROW_W));
        addr = make_addr(1'(r), b, row);
        access(m, addr, 1'b0, next_random(), BE_W'(next_random()));
        access(m, addr, 1'b1, '0, '0);
        wait_idle();
      end
    end
  endtask

  // stored word lands in the decoded array only
  task automatic test_region_ports();
    logic [DATA_W-1:0]  data;
    int                 b;
    int                 row;
    for (int r = 0; r < 2; r++)
    begin
      b    = int'(next_random() % N_BANK);
      row  = int'(next_random() % (r ? 2**SCM_ROW_W : 2**SRAM_ROW_W));
      data = next_random();
      access(0, make_addr(1'(r), b, row), 1'b0, data, '1);
      wait_idle();
      if (r == 0)
      begin
        check_rdata($sformatf("sram_mem[%0d][%0d]", b, row), i_mem.sram_mem[b][row], data);
        check_rdata($sformatf("scm_mem[%0d][%0d]", b, row % 256),
                    i_mem.scm_mem[b][row % 256], ref_mem[1][b][row % 256]);
      end
      else
      begin
        check_rdata($sformatf("scm_mem[%0d][%0d]", b, row), i_mem.scm_mem[b][row], data);
        check_rdata($sformatf("sram_mem[%0d][%0d]", b, row),
                    i_mem.sram_mem[b][row], ref_mem[0][b][row]);
      end
    end
  endtask

  task automatic test_parallel_banks();
    int k;
    k = int'(next_random() % N_BANK);
    @(posedge clk);
    for (int m = 0; m < N_MASTER; m++)
      master_req[m] <= req_word(make_addr(1'(next_random()), (m + k) % N_BANK,
                                          int'(next_random() % 256)), 1'b1, '0, '0);
    @(negedge clk);
    check_gnt("master_gnt_o", master_gnt, '1);
    @(posedge clk);
    for (int m = 0; m < N_MASTER; m++)
      master_req[m].req <= 1'b0;
    wait_idle();
  endtask

  // masters 1 and 3 share one bank so the grants alternate
  task automatic test_shared_bank();
    logic [ADDR_W-1:0]  addrs [2][4];
    int                 b;
    int                 win;
    b = int'(next_random() % N_BANK);
    for (int i = 0; i < 2; i++)
      for (int j = 0; j < 4; j++)
        addrs[i][j] = make_addr(1'(j), b, 16 * i + j + 3);
    @(posedge clk);
    master_req[1] <= req_word(addrs[0][0], 1'b1, '0, '0);
    master_req[3] <= req_word(addrs[1][0], 1'b1, '0, '0);
    for (int s = 0; s < 8; s++)
    begin
      win = s % 2;
      @(negedge clk);
      check_gnt("master_gnt_o", master_gnt, N_MASTER'(1) << (2 * win + 1));
      @(posedge clk);
      if (s < 6)
        master_req[2 * win + 1] <= req_word(addrs[win][s / 2 + 1], 1'b1, '0, '0);
      else
        master_req[2 * win + 1].req <= 1'b0;
    end
    wait_idle();
  endtask

  // four stores then four loads with one access per cycle
  task automatic test_back_to_back();
    logic [ADDR_W-1:0]  addrs [4];
    for (int i = 0; i < 4; i++)
      addrs[i] = make_addr(1'(i), int'(next_random() % N_BANK), int'(next_random() % 256));
    @(posedge clk);
    master_req[2] <= req_word(addrs[0], 1'b0, next_random(), '1);
    for (int s = 0; s < 8; s++)
    begin
      // lone master, granted in the cycle of its request
      @(negedge clk);
      check_gnt("master_gnt_o", master_gnt, N_MASTER'(1) << 2);
      @(posedge clk);
      if (s < 7)
        master_req[2] <= req_word(addrs[(s + 1) % 4], 1'((s + 1) >= 4), next_random(), '1);
      else
        master_req[2].req <= 1'b0;
    end
    wait_idle();
  endtask

  initial
  begin
    rst_n      = 1'b0;
    master_req = '0;
    for (int r = 0; r < 2; r++)
      for (int b = 0; b < N_BANK; b++)
        for (int w = 0; w < 2**SRAM_ROW_W; w++)
          ref_mem[r][b][w] = 32'h3c00_0000 | (r << 20) | (b << 16) | w;
    apply_reset();
    test_reset_state();
    test_write_read();
    test_region_ports();
    test_parallel_banks();
    // arbiter pointers back to master 0 first
    apply_reset();
    test_shared_bank();
    test_back_to_back();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- xbar/tcdm_bank_arbiter.sv
/*
  round-robin arbiter of one bank
  - priority mask above the last winner
  - falls back to plain lowest index when the mask is empty
*/
`timescale 1ns/1ps

module tcdm_bank_arbiter
  import tcdm_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic [N_MASTER-1:0]  req_i,
  output master_id_t           gnt_o
);

  // set bits have priority, all ones gives master 0 the lead
  logic [N_MASTER-1:0]  prio_mask_q;
  logic [N_MASTER-1:0]  req_masked;
  logic [N_MASTER-1:0]  req_sel;

  // requests above the last winner first
  assign req_masked = req_i & prio_mask_q;
  assign req_sel    = (|req_masked) ? req_masked : req_i;

  // lowest set bit of the selected vector
  assign gnt_o = req_sel & (~req_sel + 1'b1);

  // winner drops to the lowest priority
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
      prio_mask_q <= '1;
    else if (|gnt_o)
      prio_mask_q <= ~(gnt_o | (gnt_o - 1'b1));
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_gnt_onehot : assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0(gnt_o));

  // no grant without a request in the same cycle
  a_gnt_has_req : assert property (@(posedge clk) disable iff (!rst_n_i)
    (gnt_o & ~req_i) == '0);

endmodule

//--- xbar/tcdm_xbar_req.sv
/*
  request crossbar
  - address decode of every master into bank, region and row
  - one round-robin arbiter per bank
  - winner mux onto the bank request, grant return to the masters
*/
`timescale 1ns/1ps

module tcdm_xbar_req
  import tcdm_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst_n_i,
  input  master_req_t [N_MASTER-1:0]   master_req_i,
  output logic [N_MASTER-1:0]          master_gnt_o,
  output bank_req_t [N_BANK-1:0]       bank_req_o
);

  // decoded fields per master
  tcdm_addr_u [N_MASTER-1:0]              m_addr;
  logic [N_MASTER-1:0][BANK_W-1:0]        m_bank;
  region_e [N_MASTER-1:0]                 m_region;
  logic [N_MASTER-1:0][SRAM_ROW_W-1:0]    m_row;

  // request and grant matrices
  logic [N_BANK-1:0][N_MASTER-1:0]        bank_reqs;
  master_id_t [N_BANK-1:0]                bank_gnt;
  logic [N_MASTER-1:0][N_BANK-1:0]        gnt_by_master;

  // decode through the union, scm rows are zero extended
  always_comb
  begin
    for (int m = 0; m < N_MASTER; m++)
    begin
      m_addr[m]   = master_req_i[m].addr[REGION_BIT:0];
      m_bank[m]   = m_addr[m].sram.bank;
      m_region[m] = m_addr[m].sram.region;
      if (m_region[m] == SCM)
        m_row[m] = SRAM_ROW_W'(m_addr[m].scm.row);
      else
        m_row[m] = m_addr[m].sram.row;
    end
  end

  // one request line per master and bank
  always_comb
  begin
    for (int b = 0; b < N_BANK; b++)
      for (int m = 0; m < N_MASTER; m++)
        bank_reqs[b][m] = master_req_i[m].req && (m_bank[m] == BANK_W'(b));
  end

  for (genvar b = 0; b < N_BANK; b++)
  begin : g_arb
    tcdm_bank_arbiter i_bank_arbiter
    (
      .clk     ( clk          ),
      .rst_n_i ( rst_n_i      ),
      .req_i   ( bank_reqs[b] ),
      .gnt_o   ( bank_gnt[b]  )
    );
  end

  // winner mux, grant is one-hot so the last match is the only one
  always_comb
  begin
    for (int b = 0; b < N_BANK; b++)
    begin
      bank_req_o[b] = '0;
      for (int m = 0; m < N_MASTER; m++)
      begin
        if (bank_gnt[b][m])
        begin
          bank_req_o[b].region = m_region[m];
          bank_req_o[b].row    = m_row[m];
          bank_req_o[b].wen    = master_req_i[m].wen;
          bank_req_o[b].wdata  = master_req_i[m].wdata;
          bank_req_o[b].be     = master_req_i[m].be;
        end
      end
      bank_req_o[b].req = |bank_gnt[b];
      bank_req_o[b].id  = bank_gnt[b];
    end
  end

  // grant back to masters, OR over the banks
  always_comb
  begin
    for (int m = 0; m < N_MASTER; m++)
    begin
      for (int b = 0; b < N_BANK; b++)
        gnt_by_master[m][b] = bank_gnt[b][m];
      master_gnt_o[m] = |gnt_by_master[m];
    end
  end

  // decode and arbiters together must never hand a master two banks
  for (genvar m = 0; m < N_MASTER; m++)
  begin : g_gnt_chk
    a_single_bank : assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0(gnt_by_master[m]));
  end

endmodule
